// File: hw/rate_ctrl_macros.svh
// Rate control widths, limits and gains
`ifndef RATE_CTRL_MACROS_SVH
`define RATE_CTRL_MACROS_SVH

// Signed 12.4 rate values
`define RATE_W       16
`define RATE_LIMIT   4000
`define INTEG_LIMIT  16000

// Unsigned motor commands
`define MOTOR_W      12
`define MOTOR_MAX    4095

// Yaw loop gains
`define YAW_K_P          31
`define YAW_K_P_SHIFT    4
`define YAW_K_I          1
`define YAW_K_I_SHIFT    4
`define YAW_K_D          4
`define YAW_K_D_SHIFT    4

// Roll loop gains
`define ROLL_K_P         4
`define ROLL_K_P_SHIFT   4
`define ROLL_K_I         1
`define ROLL_K_I_SHIFT   4
`define ROLL_K_D         1
`define ROLL_K_D_SHIFT   4

// Pitch loop gains
`define PITCH_K_P        4
`define PITCH_K_P_SHIFT  4
`define PITCH_K_I        1
`define PITCH_K_I_SHIFT  4
`define PITCH_K_D        1
`define PITCH_K_D_SHIFT  4

`endif

// File: hw/rate_ctrl_pkg.sv
// Rate control shared types
`include "rate_ctrl_macros.svh"

package rate_ctrl_pkg;

	// One signed 12.4 rate per rotation axis
	typedef struct packed {
		logic signed [`RATE_W-1:0] yaw;
		logic signed [`RATE_W-1:0] roll;
		logic signed [`RATE_W-1:0] pitch;
	} axis_rates_t;

	// Commands for the four rotors
	typedef struct packed {
		logic [`MOTOR_W-1:0] m_front_left;
		logic [`MOTOR_W-1:0] m_front_right;
		logic [`MOTOR_W-1:0] m_rear_left;
		logic [`MOTOR_W-1:0] m_rear_right;
	} motor_cmd_t;

	// Axis loop sequence, one multiplier pass per term
	typedef enum logic [2:0] {
		PID_IDLE,
		PID_P,
		PID_I,
		PID_D,
		PID_SUM,
		PID_DONE
	} pid_state_e;

	// Control cycle sequence
	typedef enum logic [1:0] {
		CTRL_WAITING,
		CTRL_ACTIVE,
		CTRL_COMPLETE
	} ctrl_state_e;

endpackage

// File: hw/pid.sv
// Single axis PID loop
`include "rate_ctrl_macros.svh"

module pid
	import rate_ctrl_pkg::*;
#(
	parameter int K_P     = 1,
	parameter int K_I     = 0,
	parameter int K_D     = 0,
	parameter int P_SHIFT = 4,
	parameter int I_SHIFT = 4,
	parameter int D_SHIFT = 4
) (
	input  logic                      us_clk,
	input  logic                      resetn,
	input  logic                      start,
	input  logic signed [`RATE_W-1:0] target,
	input  logic signed [`RATE_W-1:0] measured,
	input  logic signed [`RATE_W-1:0] angle_error,
	output logic signed [`RATE_W-1:0] rate_out,
	output logic                      pid_done
);

	// Error holds three summed rates, the difference one more bit
	localparam int ERR_W  = `RATE_W + 3;
	localparam int GAIN_W = `RATE_W;
	localparam int MUL_W  = ERR_W + GAIN_W;
	localparam int SUM_W  = MUL_W + 2;
	localparam int SH_W   = 5;

	localparam logic signed [GAIN_W-1:0] GAIN_P = GAIN_W'(K_P);
	localparam logic signed [GAIN_W-1:0] GAIN_I = GAIN_W'(K_I);
	localparam logic signed [GAIN_W-1:0] GAIN_D = GAIN_W'(K_D);
	localparam logic [SH_W-1:0] SH_P = SH_W'(P_SHIFT);
	localparam logic [SH_W-1:0] SH_I = SH_W'(I_SHIFT);
	localparam logic [SH_W-1:0] SH_D = SH_W'(D_SHIFT);

	pid_state_e state;

	logic signed [ERR_W-1:0]  err_calc;
	logic signed [ERR_W-1:0]  err;
	logic signed [ERR_W-1:0]  prev_err;
	logic signed [ERR_W-1:0]  integral;
	logic signed [ERR_W:0]    integ_sum;
	logic signed [ERR_W-1:0]  d_diff;
	logic signed [ERR_W-1:0]  mul_a;
	logic signed [GAIN_W-1:0] mul_b;
	logic [SH_W-1:0]          mul_sh;
	logic signed [MUL_W-1:0]  mul_prod;
	logic signed [MUL_W-1:0]  mul_term;
	logic signed [MUL_W-1:0]  p_term;
	logic signed [MUL_W-1:0]  i_term;
	logic signed [MUL_W-1:0]  d_term;
	logic signed [SUM_W-1:0]  pid_sum;

	function automatic logic signed [ERR_W-1:0] clamp_integ(input logic signed [ERR_W:0] v);
		if (v > `INTEG_LIMIT)
			return ERR_W'(`INTEG_LIMIT);
		if (v < -`INTEG_LIMIT)
			return ERR_W'(-`INTEG_LIMIT);
		return v[ERR_W-1:0];
	endfunction

	function automatic logic signed [`RATE_W-1:0] clamp_rate(input logic signed [SUM_W-1:0] v);
		if (v > `RATE_LIMIT)
			return `RATE_W'(`RATE_LIMIT);
		if (v < -`RATE_LIMIT)
			return `RATE_W'(-`RATE_LIMIT);
		return v[`RATE_W-1:0];
	endfunction

	assign err_calc  = target - measured + angle_error;
	assign integ_sum = integral + err;
	assign d_diff    = err - prev_err;
	assign pid_sum   = p_term + i_term + d_term;

	// One multiplier, operands picked by the current term
	always_comb begin
		case (state)
			PID_I: begin
				mul_a  = integral;
				mul_b  = GAIN_I;
				mul_sh = SH_I;
			end
			PID_D: begin
				mul_a  = d_diff;
				mul_b  = GAIN_D;
				mul_sh = SH_D;
			end
			default: begin
				mul_a  = err;
				mul_b  = GAIN_P;
				mul_sh = SH_P;
			end
		endcase
	end

	assign mul_prod = mul_a * mul_b;
	assign mul_term = mul_prod >>> mul_sh;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state    <= PID_IDLE;
			integral <= '0;
			prev_err <= '0;
			rate_out <= '0;
		end else begin
			case (state)
				PID_IDLE: begin
					if (start)
						state <= PID_P;
				end
				PID_P: begin
					// Integral is ready for the next pass
					integral <= clamp_integ(integ_sum);
					state    <= PID_I;
				end
				PID_I: state <= PID_D;
				PID_D: begin
					prev_err <= err;
					state    <= PID_SUM;
				end
				PID_SUM: begin
					rate_out <= clamp_rate(pid_sum);
					state    <= PID_DONE;
				end
				default: state <= PID_IDLE;
			endcase
		end
	end

	// Error and term registers
	always_ff @(posedge us_clk) begin
		if (state == PID_IDLE && start)
			err <= err_calc;
		case (state)
			PID_P: p_term <= mul_term;
			PID_I: i_term <= mul_term;
			PID_D: d_term <= mul_term;
			default: ;
		endcase
	end

	assign pid_done = (state == PID_DONE);

endmodule

// File: hw/body_frame_controller.sv
// Body frame rate controller
`include "rate_ctrl_macros.svh"

module body_frame_controller
	import rate_ctrl_pkg::*;
(
	input  logic                      us_clk,
	input  logic                      resetn,
	input  logic                      start_signal,
	input  axis_rates_t               target,
	input  axis_rates_t               rotation,
	input  logic signed [`RATE_W-1:0] roll_angle_error,
	input  logic signed [`RATE_W-1:0] pitch_angle_error,
	output axis_rates_t               rates,
	output logic                      complete_signal
);

	ctrl_state_e state;

	logic start_d;
	logic start_rise;
	logic launch;
	logic pid_start;
	// Sticky done bits, yaw roll pitch from high to low
	logic [2:0] done_flags;
	logic yaw_done;
	logic roll_done;
	logic pitch_done;

	axis_rates_t               lat_target;
	axis_rates_t               lat_meas;
	logic signed [`RATE_W-1:0] lat_roll_err;
	logic signed [`RATE_W-1:0] lat_pitch_err;
	logic signed [`RATE_W-1:0] yaw_rate;
	logic signed [`RATE_W-1:0] roll_rate;
	logic signed [`RATE_W-1:0] pitch_rate;

	assign start_rise = start_signal && !start_d;
	// Edges during a running cycle are dropped
	assign launch = start_rise && (state == CTRL_WAITING);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state      <= CTRL_WAITING;
			start_d    <= 1'b0;
			pid_start  <= 1'b0;
			done_flags <= '0;
		end else begin
			start_d   <= start_signal;
			pid_start <= launch;
			case (state)
				CTRL_WAITING: begin
					if (launch) begin
						done_flags <= '0;
						state      <= CTRL_ACTIVE;
					end
				end
				CTRL_ACTIVE: begin
					done_flags <= done_flags | {yaw_done, roll_done, pitch_done};
					if (&done_flags)
						state <= CTRL_COMPLETE;
				end
				default: state <= CTRL_WAITING;
			endcase
		end
	end

	// IMU yaw and pitch axes point opposite to the body frame
	always_ff @(posedge us_clk) begin
		if (launch) begin
			lat_target     <= target;
			lat_meas.yaw   <= -rotation.yaw;
			lat_meas.roll  <= rotation.roll;
			lat_meas.pitch <= -rotation.pitch;
			lat_roll_err   <= roll_angle_error;
			lat_pitch_err  <= pitch_angle_error;
		end
	end

	assign complete_signal = (state == CTRL_COMPLETE);
	assign rates = '{yaw: yaw_rate, roll: roll_rate, pitch: pitch_rate};

	// Yaw has no angle loop above it
	pid #(
		.K_P(`YAW_K_P), .K_I(`YAW_K_I), .K_D(`YAW_K_D),
		.P_SHIFT(`YAW_K_P_SHIFT), .I_SHIFT(`YAW_K_I_SHIFT), .D_SHIFT(`YAW_K_D_SHIFT)
	) yaw_pid (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (pid_start),
		.target      (lat_target.yaw),
		.measured    (lat_meas.yaw),
		.angle_error ('0),
		.rate_out    (yaw_rate),
		.pid_done    (yaw_done)
	);

	pid #(
		.K_P(`ROLL_K_P), .K_I(`ROLL_K_I), .K_D(`ROLL_K_D),
		.P_SHIFT(`ROLL_K_P_SHIFT), .I_SHIFT(`ROLL_K_I_SHIFT), .D_SHIFT(`ROLL_K_D_SHIFT)
	) roll_pid (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (pid_start),
		.target      (lat_target.roll),
		.measured    (lat_meas.roll),
		.angle_error (lat_roll_err),
		.rate_out    (roll_rate),
		.pid_done    (roll_done)
	);

	pid #(
		.K_P(`PITCH_K_P), .K_I(`PITCH_K_I), .K_D(`PITCH_K_D),
		.P_SHIFT(`PITCH_K_P_SHIFT), .I_SHIFT(`PITCH_K_I_SHIFT), .D_SHIFT(`PITCH_K_D_SHIFT)
	) pitch_pid (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (pid_start),
		.target      (lat_target.pitch),
		.measured    (lat_meas.pitch),
		.angle_error (lat_pitch_err),
		.rate_out    (pitch_rate),
		.pid_done    (pitch_done)
	);

endmodule

// File: hw/motor_mixer.sv
// Quad X motor mixer
`include "rate_ctrl_macros.svh"

module motor_mixer
	import rate_ctrl_pkg::*;
(
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 load,
	input  axis_rates_t          rates,
	input  logic [`MOTOR_W-1:0]  throttle,
	output motor_cmd_t           motors,
	output logic                 mix_valid
);

	// Throttle plus three integer rate terms and a sign bit
	localparam int MIX_W  = `MOTOR_W + 3;
	localparam int FRAC_W = 4;

	logic signed [MIX_W-1:0] thr_s;
	logic signed [MIX_W-1:0] yaw_i;
	logic signed [MIX_W-1:0] roll_i;
	logic signed [MIX_W-1:0] pitch_i;
	logic signed [MIX_W-1:0] mix_fl;
	logic signed [MIX_W-1:0] mix_fr;
	logic signed [MIX_W-1:0] mix_rl;
	logic signed [MIX_W-1:0] mix_rr;

	function automatic logic [`MOTOR_W-1:0] clamp_motor(input logic signed [MIX_W-1:0] v);
		if (v < 0)
			return '0;
		if (v > `MOTOR_MAX)
			return `MOTOR_W'(`MOTOR_MAX);
		return v[`MOTOR_W-1:0];
	endfunction

	assign thr_s = MIX_W'(throttle);

	// Drop the fractional bits of each rate
	assign yaw_i   = MIX_W'(rates.yaw >>> FRAC_W);
	assign roll_i  = MIX_W'(rates.roll >>> FRAC_W);
	assign pitch_i = MIX_W'(rates.pitch >>> FRAC_W);

	assign mix_fl = thr_s + pitch_i + roll_i - yaw_i;
	assign mix_fr = thr_s + pitch_i - roll_i + yaw_i;
	assign mix_rl = thr_s - pitch_i + roll_i + yaw_i;
	assign mix_rr = thr_s - pitch_i - roll_i - yaw_i;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motors    <= '0;
			mix_valid <= 1'b0;
		end else begin
			mix_valid <= load;
			if (load) begin
				motors <= '{
					m_front_left:  clamp_motor(mix_fl),
					m_front_right: clamp_motor(mix_fr),
					m_rear_left:   clamp_motor(mix_rl),
					m_rear_right:  clamp_motor(mix_rr)
				};
			end
		end
	end

endmodule

// File: hw/flight_rate_top.sv
// Flight rate control stage
`include "rate_ctrl_macros.svh"

module flight_rate_top
	import rate_ctrl_pkg::*;
(
	input  logic                      us_clk,
	input  logic                      resetn,
	input  logic                      start_signal,
	input  axis_rates_t               target,
	input  axis_rates_t               rotation,
	input  logic signed [`RATE_W-1:0] roll_angle_error,
	input  logic signed [`RATE_W-1:0] pitch_angle_error,
	input  logic [`MOTOR_W-1:0]       throttle,
	output axis_rates_t               rates,
	output logic                      complete_signal,
	output motor_cmd_t                motors,
	output logic                      mix_valid
);

	body_frame_controller u_body_frame_controller (
		.us_clk            (us_clk),
		.resetn            (resetn),
		.start_signal      (start_signal),
		.target            (target),
		.rotation          (rotation),
		.roll_angle_error  (roll_angle_error),
		.pitch_angle_error (pitch_angle_error),
		.rates             (rates),
		.complete_signal   (complete_signal)
	);

	// Mixer picks up the new rates on the complete pulse
	motor_mixer u_motor_mixer (
		.us_clk    (us_clk),
		.resetn    (resetn),
		.load      (complete_signal),
		.rates     (rates),
		.throttle  (throttle),
		.motors    (motors),
		.mix_valid (mix_valid)
	);

endmodule

// File: tests/tb_flight_rate_top.sv
// Flight rate stage testbench
`include "rate_ctrl_macros.svh"

module tb_flight_rate_top
	import rate_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 50;

	logic                      us_clk;
	logic                      resetn;
	logic                      start_signal;
	axis_rates_t               target;
	axis_rates_t               rotation;
	logic signed [`RATE_W-1:0] roll_angle_error;
	logic signed [`RATE_W-1:0] pitch_angle_error;
	logic [`MOTOR_W-1:0]       throttle;
	axis_rates_t               rates;
	logic                      complete_signal;
	motor_cmd_t                motors;
	logic                      mix_valid;

	int          errors;
	int          checks;
	int          tests;
	int          test_errors;
	logic [31:0] rand_state;
	// Model history per axis in yaw roll pitch order
	longint      integ_mem[3];
	longint      prev_mem[3];

	flight_rate_top u_flight_rate_top (.*);

	initial us_clk = 1'b0;
	always #20 us_clk = ~us_clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	// Mixer output trails the complete pulse by one cycle
	assert property (@(posedge us_clk) disable iff (!resetn) complete_signal |=> mix_valid)
		else report_failure("mix_valid did not follow complete_signal");
	assert property (@(posedge us_clk) disable iff (!resetn) mix_valid |-> $past(complete_signal))
		else report_failure("mix_valid rose without a complete_signal before it");
	assert property (@(posedge us_clk) disable iff (!resetn) complete_signal |=> !complete_signal)
		else report_failure("complete_signal stayed high for more than one cycle");

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic int random_range(input int lo, input int hi);
		logic [31:0] r;
		r = next_random();
		return lo + int'((r >> 8) % 32'(hi - lo + 1));
	endfunction

	function automatic axis_rates_t make_rates(input int y, input int r, input int p);
		axis_rates_t v;
		v.yaw   = `RATE_W'(y);
		v.roll  = `RATE_W'(r);
		v.pitch = `RATE_W'(p);
		return v;
	endfunction

	function automatic axis_rates_t random_rates(input int span);
		return make_rates(random_range(-span, span - 1), random_range(-span, span - 1),
			random_range(-span, span - 1));
	endfunction

	function automatic longint clamp(input longint v, input longint lo, input longint hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	function automatic longint model_pid(input int axis, input longint err, input int kp,
		input int ki, input int kd, input int ps, input int is, input int ds);
		longint p_val;
		longint i_val;
		longint d_val;
		integ_mem[axis] = clamp(integ_mem[axis] + err, -`INTEG_LIMIT, `INTEG_LIMIT);
		p_val = (err * kp) >>> ps;
		i_val = (integ_mem[axis] * ki) >>> is;
		d_val = ((err - prev_mem[axis]) * kd) >>> ds;
		prev_mem[axis] = err;
		return clamp(p_val + i_val + d_val, -`RATE_LIMIT, `RATE_LIMIT);
	endfunction

	// IMU yaw and pitch are negated and yaw sees no angle error
	function automatic axis_rates_t model_rates(input axis_rates_t tgt, input axis_rates_t rot,
		input int rerr, input int perr);
		axis_rates_t res;
		longint err_y;
		longint err_r;
		longint err_p;
		err_y = $signed(tgt.yaw) - (-$signed(rot.yaw));
		err_r = $signed(tgt.roll) - $signed(rot.roll) + rerr;
		err_p = $signed(tgt.pitch) - (-$signed(rot.pitch)) + perr;
		res.yaw = `RATE_W'(model_pid(0, err_y, `YAW_K_P, `YAW_K_I, `YAW_K_D,
			`YAW_K_P_SHIFT, `YAW_K_I_SHIFT, `YAW_K_D_SHIFT));
		res.roll = `RATE_W'(model_pid(1, err_r, `ROLL_K_P, `ROLL_K_I, `ROLL_K_D,
			`ROLL_K_P_SHIFT, `ROLL_K_I_SHIFT, `ROLL_K_D_SHIFT));
		res.pitch = `RATE_W'(model_pid(2, err_p, `PITCH_K_P, `PITCH_K_I, `PITCH_K_D,
			`PITCH_K_P_SHIFT, `PITCH_K_I_SHIFT, `PITCH_K_D_SHIFT));
		return res;
	endfunction

	function automatic motor_cmd_t model_mix(input axis_rates_t r_in, input int thr);
		motor_cmd_t res;
		longint y;
		longint r;
		longint p;
		y = $signed(r_in.yaw) >>> 4;
		r = $signed(r_in.roll) >>> 4;
		p = $signed(r_in.pitch) >>> 4;
		res.m_front_left  = `MOTOR_W'(clamp(thr + p + r - y, 0, `MOTOR_MAX));
		res.m_front_right = `MOTOR_W'(clamp(thr + p - r + y, 0, `MOTOR_MAX));
		res.m_rear_left   = `MOTOR_W'(clamp(thr - p + r + y, 0, `MOTOR_MAX));
		res.m_rear_right  = `MOTOR_W'(clamp(thr - p - r - y, 0, `MOTOR_MAX));
		return res;
	endfunction

	task automatic step();
		@(posedge us_clk);
		#2;
	endtask

	task automatic apply_reset();
		resetn = 1'b0;
		start_signal = 1'b0;
		repeat (2) step();
		resetn = 1'b1;
		for (int a = 0; a < 3; a++) begin
			integ_mem[a] = 0;
			prev_mem[a] = 0;
		end
	endtask

	task automatic begin_test();
		test_errors = 0;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %-12s finished with %0d errors", name, test_errors);
	endtask

	task automatic check_value(input string name, input string what, input longint expected,
		input longint actual);
		checks++;
		assert (actual == expected)
			else report_failure($sformatf("MISMATCH %s %s expected %0d actual %0d",
				name, what, expected, actual));
	endtask

	task automatic check_true(input string name, input logic cond, input string msg);
		checks++;
		assert (cond)
			else report_failure($sformatf("%s: %s", name, msg));
	endtask

	task automatic wait_complete(input string name);
		int cycles;
		cycles = 0;
		while (!complete_signal && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
		end
		if (!complete_signal) begin
			$display("%s: timed out waiting for complete_signal", name);
			$display("** FAIL **");
			$finish;
		end
	endtask

	// One full control cycle checked against the model
	task automatic run_cycle(input string name, input axis_rates_t tgt, input axis_rates_t rot,
		input int rerr, input int perr, input int thr, output axis_rates_t got);
		axis_rates_t exp_rates;
		motor_cmd_t  exp_motors;
		target = tgt;
		rotation = rot;
		roll_angle_error = `RATE_W'(rerr);
		pitch_angle_error = `RATE_W'(perr);
		throttle = `MOTOR_W'(thr);
		start_signal = 1'b1;
		exp_rates = model_rates(tgt, rot, rerr, perr);
		exp_motors = model_mix(exp_rates, thr);
		wait_complete(name);
		check_value(name, "rates.yaw", $signed(exp_rates.yaw), $signed(rates.yaw));
		check_value(name, "rates.roll", $signed(exp_rates.roll), $signed(rates.roll));
		check_value(name, "rates.pitch", $signed(exp_rates.pitch), $signed(rates.pitch));
		got = rates;
		step();
		check_true(name, mix_valid, "mix_valid was low one cycle after complete_signal");
		check_value(name, "motors", longint'(exp_motors), longint'(motors));
		start_signal = 1'b0;
		step();
	endtask

	initial begin
		axis_rates_t got;
		axis_rates_t exp_rates;
		longint      first_roll;
		longint      last_roll;
		int          extra;
		rand_state = 32'h3a12e840;
		errors = 0;
		checks = 0;
		tests = 0;
		resetn = 1'b0;
		start_signal = 1'b0;
		target = '0;
		rotation = '0;
		roll_angle_error = '0;
		pitch_angle_error = '0;
		throttle = '0;
		apply_reset();

		begin_test();
		check_value("reset", "rates", 0, longint'(rates));
		check_value("reset", "motors", 0, longint'(motors));
		check_true("reset", !complete_signal && !mix_valid,
			"complete or mix_valid high after reset");
		end_test("reset");

		// Positive IMU yaw and pitch turn into positive error
		begin_test();
		run_cycle("sign_prop", make_rates(0, 0, 0), make_rates(320, 320, 320), 0, 0, 2048, got);
		check_true("sign_prop", $signed(got.yaw) > 0, "yaw measurement was not negated");
		check_true("sign_prop", $signed(got.roll) < 0, "roll measurement changed sign");
		check_true("sign_prop", $signed(got.pitch) > 0, "pitch measurement was not negated");
		repeat (6)
			run_cycle("sign_prop", random_rates(1024), random_rates(1024), 0, 0,
				random_range(0, `MOTOR_MAX), got);
		end_test("sign_prop");

		begin_test();
		apply_reset();
		for (int k = 0; k < 5; k++) begin
			run_cycle("memory", make_rates(160, 160, 160), make_rates(0, 0, 0), 0, 0,
				2048, got);
			if (k == 0)
				first_roll = $signed(got.roll);
			else
				check_true("memory", $signed(got.roll) >= last_roll, "roll output did not grow");
			last_roll = $signed(got.roll);
		end
		check_true("memory", last_roll > first_roll, "integral did not raise the roll output");
		apply_reset();
		check_value("memory", "rates after reset", 0, longint'(rates));
		run_cycle("memory", make_rates(160, 160, 160), make_rates(0, 0, 0), 0, 0, 2048, got);
		check_value("memory", "roll after reset", first_roll, $signed(got.roll));
		end_test("memory");

		begin_test();
		run_cycle("saturate", make_rates(-15000, 20000, 20000), make_rates(-15000, -20000, 20000),
			0, 0, `MOTOR_MAX, got);
		check_value("saturate", "yaw clamp", -`RATE_LIMIT, $signed(got.yaw));
		check_value("saturate", "roll clamp", `RATE_LIMIT, $signed(got.roll));
		check_value("saturate", "pitch clamp", `RATE_LIMIT, $signed(got.pitch));
		check_value("saturate", "front left max", `MOTOR_MAX, motors.m_front_left);
		run_cycle("saturate", make_rates(-15000, 20000, 20000), make_rates(-15000, -20000, 20000),
			0, 0, 0, got);
		check_value("saturate", "rear right min", 0, motors.m_rear_right);
		end_test("saturate");

		// Start held high with an extra edge while busy
		begin_test();
		target = random_rates(1024);
		rotation = random_rates(1024);
		roll_angle_error = '0;
		pitch_angle_error = '0;
		throttle = `MOTOR_W'(1000);
		start_signal = 1'b1;
		exp_rates = model_rates(target, rotation, 0, 0);
		step();
		start_signal = 1'b0;
		step();
		// New inputs on the busy edge must not reach the result
		target = random_rates(1024);
		rotation = random_rates(1024);
		start_signal = 1'b1;
		wait_complete("sequence");
		check_value("sequence", "rates", longint'(exp_rates), longint'(rates));
		step();
		check_true("sequence", mix_valid, "mix_valid was low one cycle after complete_signal");
		extra = 0;
		repeat (20) begin
			step();
			if (complete_signal)
				extra++;
		end
		check_value("sequence", "extra complete pulses", 0, extra);
		check_value("sequence", "rates held", longint'(exp_rates), longint'(rates));
		start_signal = 1'b0;
		step();
		end_test("sequence");

		begin_test();
		apply_reset();
		run_cycle("angle_error", make_rates(0, 0, 0), make_rates(0, 0, 0), 320, -320, 2048, got);
		check_value("angle_error", "yaw", 0, $signed(got.yaw));
		check_true("angle_error", $signed(got.roll) > 0, "roll angle error had no effect");
		check_true("angle_error", $signed(got.pitch) < 0, "pitch angle error had no effect");
		run_cycle("angle_error", random_rates(512), random_rates(512), random_range(-512, 511),
			random_range(-512, 511), 2048, got);
		end_test("angle_error");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hw
hw/rate_ctrl_pkg.sv
hw/pid.sv
hw/body_frame_controller.sv
hw/motor_mixer.sv
hw/flight_rate_top.sv
tests/tb_flight_rate_top.sv

// File: Bender.yml
package:
  name: flight_rate_ctrl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rate_ctrl_pkg.sv
      - hw/pid.sv
      - hw/body_frame_controller.sv
      - hw/motor_mixer.sv
      - hw/flight_rate_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_flight_rate_top.sv
